//--- design/itemMap_defs.svh
// item map limits, grid geometry, field widths and random generator constants
`ifndef ITEM_MAP_DEFS_SVH
`define ITEM_MAP_DEFS_SVH

// map capacity
`define ITEM_MAX_ITEMS 30

// index and quantity widths
`define ITEM_INDEX_W 5
`define ITEM_QTY_W 5

// record position fields, fixed point
`define ITEM_LEFT_W 13
`define ITEM_TOP_W 12

// grid cell pitch in fixed point
`define ITEM_GRID_STEP 256
// columns 0 to 20, rows 0 to 10
`define ITEM_COL_SPAN 20
`define ITEM_ROW_SPAN 10

// sign-magnitude move amount, sign in the top bit
`define ITEM_MOVE_W 11

// 9-bit LCG, multiplier chosen for the full period of 512
`define LCG_SEED 173
`define LCG_MUL 45
`define LCG_INC 181

`endif

//--- design/itemMapPkg.sv
// item map package with the item kind enum, index and quantity types and item record
`include "itemMap_defs.svh"

package itemMapPkg;

    // item kinds, stone first
    typedef enum logic [1:0] {
        kindStone   = 2'd0,
        kindGold    = 2'd1,
        kindDiamond = 2'd2
    } itemKind;

    // slot number in the map
    typedef logic [`ITEM_INDEX_W-1:0] itemIndex;

    // one requested quantity
    typedef logic [`ITEM_QTY_W-1:0] itemQty;

    // 32-bit record, left in the top bits
    typedef struct packed {
        // position, fixed point
        logic [`ITEM_LEFT_W-1:0] left;
        logic [`ITEM_TOP_W-1:0]  top;
        // spare, always zero
        logic [2:0]              spare;
        itemKind                 kind;
        // flags
        logic                    visible;
        logic                    moved;
    } itemRecord;

endpackage

//--- design/lcgRandom.sv
// 9-bit linear congruential random generator stepped on request
`include "itemMap_defs.svh"

module lcgRandom (
    input  logic       clock,
    input  logic       generateEn,
    input  logic       drawReq,
    output logic [8:0] randValue
);

    logic [8:0] nextValue;

    // next = mul * v + inc, mod 512 by truncation
    assign nextValue = randValue * 9'(`LCG_MUL) + 9'(`LCG_INC);

    // seed on reset
    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            randValue <= 9'(`LCG_SEED);
        end else if (drawReq) begin
            // one step per draw
            randValue <= nextValue;
        end
    end

endmodule

//--- design/placementGenerator.sv
// placement FSM with occupied-cell table, duplicate rejection and kind selection
`include "itemMap_defs.svh"

module placementGenerator
    import itemMapPkg::*;
(
    input  logic       clock,
    input  logic       generateEn,
    input  itemQty     stoneQty,
    input  itemQty     goldQty,
    input  itemQty     diamondQty,
    input  logic [8:0] randValue,
    output logic       drawReq,
    output logic       writeEn,
    output itemIndex   writeIndex,
    output itemRecord  writeRecord,
    output itemIndex   itemCount,
    output logic       generateDone
);

    typedef enum logic [1:0] {
        stateDraw,
        stateCheck,
        stateSave,
        stateDone
    } genState;

    genState    state;
    itemIndex   checkIdx;
    // occupied cells, column over row
    logic [8:0] cellTable [`ITEM_MAX_ITEMS];

    logic [4:0] drawX;
    logic [3:0] drawY;
    logic [4:0] cellCol;
    logic [3:0] cellRow;
    logic [8:0] cellCode;
    logic [5:0] stoneGoldQty;
    logic [6:0] totalQty;
    logic       allPlaced;
    logic       lastCheck;
    logic       cellTaken;
    itemKind    nextKind;

    // upper 5 bits give x, lower 4 give y
    assign {drawX, drawY} = randValue;

    // fold x back into 0..20
    assign cellCol = 5'((drawX >= 5'(`ITEM_COL_SPAN))
                        ? 6'(2 * `ITEM_COL_SPAN) - {1'b0, drawX}
                        : 6'(`ITEM_COL_SPAN) - {1'b0, drawX});
    // fold y back into 0..10
    assign cellRow = 4'((drawY >= 4'(`ITEM_ROW_SPAN))
                        ? 5'(2 * `ITEM_ROW_SPAN) - {1'b0, drawY}
                        : 5'(`ITEM_ROW_SPAN) - {1'b0, drawY});
    assign cellCode = {cellCol, cellRow};

    // quantity sums for kind and end test
    assign stoneGoldQty = 6'(stoneQty) + 6'(goldQty);
    assign totalQty = 7'(stoneGoldQty) + 7'(diamondQty);
    assign allPlaced = ({2'b00, itemCount} == totalQty);

    // one table entry compared per cycle
    assign cellTaken = (cellTable[checkIdx] == cellCode);
    assign lastCheck = ((checkIdx + 1'b1) == itemCount);

    // stones first, then gold, diamonds fill the rest
    always_comb begin
        if (itemCount < stoneQty) begin
            nextKind = kindStone;
        end else if ({1'b0, itemCount} < stoneGoldQty) begin
            nextKind = kindGold;
        end else begin
            nextKind = kindDiamond;
        end
    end

    // record of the current candidate
    always_comb begin
        writeRecord.left    = `ITEM_LEFT_W'(cellCol * `ITEM_GRID_STEP);
        writeRecord.top     = `ITEM_TOP_W'(cellRow * `ITEM_GRID_STEP);
        writeRecord.spare   = '0;
        writeRecord.kind    = nextKind;
        writeRecord.visible = 1'b1;
        writeRecord.moved   = 1'b0;
    end

    // generator steps on the edge that leaves draw
    assign drawReq = (state == stateDraw) && !allPlaced;
    assign writeEn = (state == stateSave);
    assign writeIndex = itemCount;
    assign generateDone = (state == stateDone);

    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            state     <= stateDraw;
            checkIdx  <= '0;
            itemCount <= '0;
        end else begin
            case (state)
                stateDraw: begin
                    checkIdx <= '0;
                    // empty request ends at once
                    if (allPlaced) begin
                        state <= stateDone;
                    end else if (itemCount == '0) begin
                        // nothing to compare against yet
                        state <= stateSave;
                    end else begin
                        state <= stateCheck;
                    end
                end
                stateCheck: begin
                    if (cellTaken) begin
                        // duplicate, draw again
                        state <= stateDraw;
                    end else if (lastCheck) begin
                        state <= stateSave;
                    end else begin
                        checkIdx <= checkIdx + 1'b1;
                    end
                end
                stateSave: begin
                    itemCount <= itemCount + 1'b1;
                    if (({2'b00, itemCount} + 7'd1) == totalQty) begin
                        state <= stateDone;
                    end else begin
                        state <= stateDraw;
                    end
                end
                default: begin
                    // done holds until reset
                    state <= stateDone;
                end
            endcase
        end
    end

    // table entry goes in with the record
    always_ff @(posedge clock) begin
        if (writeEn) begin
            cellTable[itemCount] <= cellCode;
        end
    end

endmodule

//--- design/itemStore.sv
// item record array with generation write port, move update and read port
`include "itemMap_defs.svh"

module itemStore
    import itemMapPkg::*;
(
    input  logic                    clock,
    input  logic                    generateEn,
    input  logic                    generateDone,
    input  logic                    writeEn,
    input  itemIndex                writeIndex,
    input  itemRecord               writeRecord,
    input  logic                    moveEn,
    input  itemIndex                moveIndex,
    input  logic [`ITEM_MOVE_W-1:0] moveX,
    input  logic [`ITEM_MOVE_W-1:0] moveY,
    input  logic                    moveState,
    input  logic                    visible,
    input  itemIndex                readIndex,
    output itemRecord               readRecord
);

    itemRecord               records [`ITEM_MAX_ITEMS];
    itemRecord               moveSource;
    itemRecord               moveResult;
    logic [`ITEM_LEFT_W-1:0] leftStep;
    logic [`ITEM_TOP_W-1:0]  topStep;
    logic                    moveHit;
    logic                    readHit;

    // moves only after generation, and only to real slots
    assign moveHit = moveEn && generateDone
                     && (moveIndex < `ITEM_INDEX_W'(`ITEM_MAX_ITEMS));
    assign readHit = (readIndex < `ITEM_INDEX_W'(`ITEM_MAX_ITEMS));

    // magnitudes, sign bit dropped
    assign leftStep = `ITEM_LEFT_W'(moveX[`ITEM_MOVE_W-2:0]);
    assign topStep = `ITEM_TOP_W'(moveY[`ITEM_MOVE_W-2:0]);

    assign moveSource = records[moveIndex];

    // position wraps in field width, kind kept
    always_comb begin
        moveResult = moveSource;
        if (moveX[`ITEM_MOVE_W-1]) begin
            moveResult.left = moveSource.left - leftStep;
        end else begin
            moveResult.left = moveSource.left + leftStep;
        end
        if (moveY[`ITEM_MOVE_W-1]) begin
            moveResult.top = moveSource.top - topStep;
        end else begin
            moveResult.top = moveSource.top + topStep;
        end
        // flags overwritten
        moveResult.moved   = moveState;
        moveResult.visible = visible;
    end

    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            for (int i = 0; i < `ITEM_MAX_ITEMS; i++) begin
                records[i] <= '0;
            end
        end else if (writeEn) begin
            // placement save
            records[writeIndex] <= writeRecord;
        end else if (moveHit) begin
            records[moveIndex] <= moveResult;
        end
    end

    // combinational read, zero past the last slot
    assign readRecord = readHit ? records[readIndex] : '0;

endmodule

//--- design/itemMapTop.sv
// item map top level joining random generator, placement FSM and record store
`include "itemMap_defs.svh"

module itemMapTop
    import itemMapPkg::*;
(
    input  logic                    clock,
    input  logic                    generateEn,
    input  itemQty                  stoneQty,
    input  itemQty                  goldQty,
    input  itemQty                  diamondQty,
    input  logic                    moveEn,
    input  itemIndex                moveIndex,
    input  logic [`ITEM_MOVE_W-1:0] moveX,
    input  logic [`ITEM_MOVE_W-1:0] moveY,
    input  logic                    moveState,
    input  logic                    visible,
    input  itemIndex                readIndex,
    output itemRecord               readRecord,
    output itemIndex                itemCount,
    output logic                    generateDone
);

    // generator handshake
    logic       drawReq;
    logic [8:0] randValue;
    // placement write port
    logic       writeEn;
    itemIndex   writeIndex;
    itemRecord  writeRecord;

    lcgRandom randomGen (
        .clock     (clock),
        .generateEn(generateEn),
        .drawReq   (drawReq),
        .randValue (randValue)
    );

    placementGenerator placement (
        .clock       (clock),
        .generateEn  (generateEn),
        .stoneQty    (stoneQty),
        .goldQty     (goldQty),
        .diamondQty  (diamondQty),
        .randValue   (randValue),
        .drawReq     (drawReq),
        .writeEn     (writeEn),
        .writeIndex  (writeIndex),
        .writeRecord (writeRecord),
        .itemCount   (itemCount),
        .generateDone(generateDone)
    );

    // store takes moves once generateDone is up
    itemStore store (
        .clock       (clock),
        .generateEn  (generateEn),
        .generateDone(generateDone),
        .writeEn     (writeEn),
        .writeIndex  (writeIndex),
        .writeRecord (writeRecord),
        .moveEn      (moveEn),
        .moveIndex   (moveIndex),
        .moveX       (moveX),
        .moveY       (moveY),
        .moveState   (moveState),
        .visible     (visible),
        .readIndex   (readIndex),
        .readRecord  (readRecord)
    );

endmodule

//--- dv/itemMapTb.sv
// item map testbench with reference model, typed compare tasks, LFSR stimulus and cycle timeout
`include "itemMap_defs.svh"

module itemMapTb
    import itemMapPkg::*;
();

    // two generations of up to 512 draws at up to 33 cycles each plus moves and reads
    localparam int TimeoutCycles = 40000;
    localparam int ResetCycles = 16;
    localparam int MoveCount = 20;

    logic                    clock;
    logic                    generateEn;
    itemQty                  stoneQty;
    itemQty                  goldQty;
    itemQty                  diamondQty;
    logic                    moveEn;
    itemIndex                moveIndex;
    logic [`ITEM_MOVE_W-1:0] moveX;
    logic [`ITEM_MOVE_W-1:0] moveY;
    logic                    moveState;
    logic                    visible;
    itemIndex                readIndex;
    itemRecord               readRecord;
    itemIndex                itemCount;
    logic                    generateDone;

    // expected contents kept in step with every accepted move
    itemRecord   expRecords [`ITEM_MAX_ITEMS];
    logic [31:0] lfsrState = 32'h714f6403;
    int          cycleCount = 0;
    int          stones;
    int          golds;
    int          total;

    itemMapTop dut_i (.*);

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            stopRun($sformatf("timeout, run not finished after %0d cycles", cycleCount));
        end
    end

    task automatic stopRun(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic checkRecord(input string name, input itemRecord actual,
                               input itemRecord expected);
        if (actual !== expected) begin
            stopRun($sformatf("Error at time %0t: %s = %h, expected %h",
                              $time, name, actual, expected));
        end
    endtask

    task automatic checkCount(input string name, input itemIndex actual, input itemIndex expected);
        if (actual !== expected) begin
            stopRun($sformatf("Error at time %0t: %s = %0d, expected %0d",
                              $time, name, actual, expected));
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            stopRun($sformatf("Error at time %0t: %s = %b, expected %b",
                              $time, name, actual, expected));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1 shifting right
    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        return {1'b0, state[31:1]} ^ (state[0] ? 32'h80200003 : 32'h0);
    endfunction

    // one step per bit taken
    function automatic logic [31:0] takeBits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value[i] = lfsrState[0];
            lfsrState = nextLfsr(lfsrState);
        end
        return value;
    endfunction

    // stones first then gold and diamonds after
    function automatic itemKind kindOf(input int n);
        if (n < stones) begin
            return kindStone;
        end else if (n < stones + golds) begin
            return kindGold;
        end
        return kindDiamond;
    endfunction

    // replay the LCG draws folding cells and rejecting repeats
    task automatic buildModel();
        int  v;
        int  col;
        int  row;
        int  cols [`ITEM_MAX_ITEMS];
        int  rows [`ITEM_MAX_ITEMS];
        bit  taken;
        v = `LCG_SEED;
        for (int i = 0; i < `ITEM_MAX_ITEMS; i++) begin
            expRecords[i] = '0;
        end
        for (int n = 0; n < total; n++) begin
            taken = 1'b1;
            while (taken) begin
                v = (`LCG_MUL * v + `LCG_INC) % 512;
                col = (v / 16 >= `ITEM_COL_SPAN) ? 40 - v / 16 : 20 - v / 16;
                row = (v % 16 >= `ITEM_ROW_SPAN) ? 20 - v % 16 : 10 - v % 16;
                taken = 1'b0;
                for (int k = 0; k < n; k++) begin
                    if (cols[k] == col && rows[k] == row) begin
                        taken = 1'b1;
                    end
                end
            end
            cols[n] = col;
            rows[n] = row;
            expRecords[n].left = `ITEM_LEFT_W'(col * `ITEM_GRID_STEP);
            expRecords[n].top = `ITEM_TOP_W'(row * `ITEM_GRID_STEP);
            expRecords[n].kind = kindOf(n);
            expRecords[n].visible = 1'b1;
        end
    endtask

    // hold reset 16 cycles while reading one slot per cycle
    task automatic resetAndCheck(input int s, input int g, input int d);
        stones = s;
        golds = g;
        total = s + g + d;
        buildModel();
        @(posedge clock);
        generateEn <= 1'b0;
        stoneQty <= itemQty'(s);
        goldQty <= itemQty'(g);
        diamondQty <= itemQty'(d);
        readIndex <= '0;
        for (int i = 0; i < ResetCycles; i++) begin
            @(negedge clock);
            checkCount("itemCount", itemCount, '0);
            checkFlag("generateDone", generateDone, 1'b0);
            checkRecord($sformatf("readRecord[%0d]", i), readRecord, '0);
            @(posedge clock);
            if (i < ResetCycles - 1) begin
                readIndex <= itemIndex'(i + 1);
            end else begin
                generateEn <= 1'b1;
            end
        end
    endtask

    task automatic waitForDone();
        @(negedge clock);
        while (!generateDone) begin
            @(negedge clock);
        end
    endtask

    // every slot against the model and unused ones zero
    task automatic compareStore();
        for (int i = 0; i < `ITEM_MAX_ITEMS; i++) begin
            @(posedge clock);
            readIndex <= itemIndex'(i);
            @(negedge clock);
            checkRecord($sformatf("readRecord[%0d]", i), readRecord, expRecords[i]);
        end
        checkCount("itemCount", itemCount, itemIndex'(total));
        checkFlag("generateDone", generateDone, 1'b1);
    endtask

    // kind by index and distinct cells read back from the DUT
    task automatic verifyPlacement();
        itemRecord placed [`ITEM_MAX_ITEMS];
        for (int i = 0; i < total; i++) begin
            @(posedge clock);
            readIndex <= itemIndex'(i);
            @(negedge clock);
            placed[i] = readRecord;
            if (placed[i].kind !== kindOf(i)) begin
                stopRun($sformatf("Error at time %0t: readRecord[%0d].kind = %0d, expected %0d",
                                  $time, i, placed[i].kind, kindOf(i)));
            end
            for (int j = 0; j < i; j++) begin
                if (placed[i].left == placed[j].left && placed[i].top == placed[j].top) begin
                    stopRun($sformatf("items %0d and %0d sit on the same cell", j, i));
                end
            end
        end
    endtask

    // sign pattern from k so all four combinations occur
    task automatic applyMove(input int k);
        int         idx;
        logic [9:0] magX;
        logic [9:0] magY;
        logic       signX;
        logic       signY;
        itemRecord  expected;
        idx = int'(takeBits(5)) % total;
        magX = 10'(takeBits(10));
        magY = 10'(takeBits(10));
        signX = 1'(k % 2);
        signY = 1'((k / 2) % 2);
        expected = expRecords[idx];
        expected.left = signX ? expected.left - 13'(magX) : expected.left + 13'(magX);
        expected.top = signY ? expected.top - 12'(magY) : expected.top + 12'(magY);
        expected.moved = 1'(takeBits(1));
        expected.visible = 1'(takeBits(1));
        expRecords[idx] = expected;
        @(posedge clock);
        moveEn <= 1'b1;
        moveIndex <= itemIndex'(idx);
        moveX <= {signX, magX};
        moveY <= {signY, magY};
        moveState <= expected.moved;
        visible <= expected.visible;
        @(posedge clock);
        moveEn <= 1'b0;
        readIndex <= itemIndex'(idx);
        @(negedge clock);
        checkRecord($sformatf("readRecord[%0d]", idx), readRecord, expected);
    endtask

    // pulses stop before the last item can finish so none lands after generateDone
    task automatic moveDuringGeneration();
        @(negedge clock);
        while (int'(itemCount) < total - 1) begin
            @(posedge clock);
            moveEn <= 1'b1;
            moveIndex <= itemIndex'(int'(takeBits(5)) % `ITEM_MAX_ITEMS);
            moveX <= 11'(takeBits(11));
            moveY <= 11'(takeBits(11));
            moveState <= 1'(takeBits(1));
            visible <= 1'(takeBits(1));
            @(posedge clock);
            moveEn <= 1'b0;
            @(negedge clock);
        end
    endtask

    initial begin
        clock = 1'b0;
        generateEn = 1'b0;
        stoneQty = '0;
        goldQty = '0;
        diamondQty = '0;
        moveEn = 1'b0;
        moveIndex = '0;
        moveX = '0;
        moveY = '0;
        moveState = 1'b0;
        visible = 1'b0;
        readIndex = '0;
        // first map with five of each kind
        resetAndCheck(5, 5, 5);
        waitForDone();
        compareStore();
        verifyPlacement();
        for (int k = 0; k < MoveCount; k++) begin
            applyMove(k);
        end
        // untouched slots must still match
        compareStore();
        // full map with moves thrown at it while it builds
        resetAndCheck(10, 0, 20);
        moveDuringGeneration();
        waitForDone();
        compareStore();
        verifyPlacement();
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- files.f
+incdir+design
design/itemMapPkg.sv
design/lcgRandom.sv
design/placementGenerator.sv
design/itemStore.sv
design/itemMapTop.sv
dv/itemMapTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the item map testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f files.f --top-module itemMapTb -o itemMapSim
./obj_dir/itemMapSim
